//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = miniCpuTb
FILELIST = src.f

BUILD   = obj_dir
BIN     = $(BUILD)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST)) verilog/miniCpu_consts.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- bench/miniCpuTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "miniCpu_consts.svh"

module miniCpuTb
	import cpuPkg::*;
();

	logic   clk;
	logic   reset;
	logic   preset;
	logic   run;
	logic   instrValid;
	word    instr;
	regAddr peekAddr;
	logic   resultValid;
	regAddr resultDest;
	word    resultData;
	word    peekData;

	localparam word presetTable [16] = '{
		`PRESET_0,  `PRESET_1,  `PRESET_2,  `PRESET_3,
		`PRESET_4,  `PRESET_5,  `PRESET_6,  `PRESET_7,
		`PRESET_8,  `PRESET_9,  `PRESET_10, `PRESET_11,
		`PRESET_12, `PRESET_13, `PRESET_14, `PRESET_15
	};

	// Pattern records, one entry per line of the file
	byte    recKind [$];
	word    recA [$];
	word    recB [$];
	word    recC [$];

	// Results still owed by the pipeline, oldest first
	regAddr expDest [$];
	word    expData [$];

	// Bank contents the records lead to
	word    expBank [`REG_COUNT];

	integer seed = 32'hb927;
	int     errors = 0;
	int     checks = 0;
	logic   loaded = 1'b0;

	miniCpuTop miniCpuTop_inst (
		.clk         (clk),
		.reset       (reset),
		.preset      (preset),
		.run         (run),
		.instrValid  (instrValid),
		.instr       (instr),
		.peekAddr    (peekAddr),
		.resultValid (resultValid),
		.resultDest  (resultDest),
		.resultData  (resultData),
		.peekData    (peekData)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic compareValue(string name, word got, word want);
		checks++;
		assert (got === want)
		else
		begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic loadPatterns();
		int    fd;
		string line;
		word   a;
		word   b;
		word   c;
		fd = $fopen("bench/miniCpu_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the pattern file bench/miniCpu_patterns.txt");
			$display("=== FAIL ===");
			$finish;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				a = '0;
				b = '0;
				c = '0;
				void'($fgets(line, fd));
				if (line.len() > 2 && line[0] != "#")
				begin
					void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, b, c));
					recKind.push_back(line[0]);
					recA.push_back(a);
					recB.push_back(b);
					recC.push_back(c);
				end
			end
			$fclose(fd);
		end
	endtask

	// Random stall cycles ahead of each instruction
	task automatic issueInstr(word code, logic expectResult, regAddr dest, word data);
		while (($random(seed) & 3) == 0)
		begin
			@(posedge clk);
			#1;
			run = 1'b0;
			instrValid = 1'b0;
		end
		@(posedge clk);
		#1;
		run = 1'b1;
		instrValid = 1'b1;
		instr = code;
		if (expectResult)
		begin
			expDest.push_back(dest);
			expData.push_back(data);
		end
	endtask

	// Returns one edge after the last owed result has been written
	task automatic drainPipeline();
		@(posedge clk);
		#1;
		run = 1'b1;
		instrValid = 1'b0;
		while (expDest.size() != 0)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic peekRegister(regAddr addr, word want);
		peekAddr = addr;
		#2;
		compareValue($sformatf("peekData[%0d]", addr), peekData, want);
	endtask

	////////////////////////////////////////
	// Result monitor
	////////////////////////////////////////

	// A result counts once, in the cycle where run lets it move on
	always @(negedge clk)
	begin
		if (!reset && run && resultValid)
		begin
			checks++;
			assert (expDest.size() != 0)
			else
			begin
				errors++;
				$display("Result for register %0d appeared at %0t with no instruction pending",
					resultDest, $time);
			end
			if (expDest.size() != 0)
			begin
				compareValue("resultDest", word'(resultDest), word'(expDest.pop_front()));
				compareValue("resultData", resultData, expData.pop_front());
			end
		end
	end

	initial
	begin
		wait (loaded);
		repeat (recKind.size() * 20 + 200) @(posedge clk);
		$display("Watchdog expired, the pipeline did not finish the patterns in time");
		$display("=== FAIL ===");
		$finish;
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		preset = 1'b1;
		run = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		peekAddr = '0;
		loadPatterns();
		loaded = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		preset = 1'b0;
		run = 1'b1;

		// Whole bank against the preset table
		for (logic [5:0] i = 0; i < `REG_COUNT; i++)
		begin
			expBank[i[4:0]] = (i < 16) ? presetTable[i[3:0]] : `PRESET_REST;
			peekRegister(i[4:0], expBank[i[4:0]]);
		end

		for (int r = 0; r < recKind.size(); r++)
		begin
			case (recKind[r])
				"I":
				begin
					issueInstr(recA[r], 1'b1, regAddr'(recB[r]), recC[r]);
					expBank[regAddr'(recB[r])] = recC[r];
				end
				"N": issueInstr(recA[r], 1'b0, '0, '0);
				"P":
				begin
					drainPipeline();
					peekRegister(regAddr'(recA[r]), recB[r]);
				end
				default:
				begin
					errors++;
					$display("Pattern record %0d has an unknown kind", r);
				end
			endcase
		end
		drainPipeline();

		// Every register against its last written value
		for (logic [5:0] i = 0; i < `REG_COUNT; i++)
			peekRegister(i[4:0], expBank[i[4:0]]);

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/miniCpu_patterns.txt
# I instr dest data   instruction and the result it must give, all hex
# N instr = nop with no result, P addr value = register peek once the pipeline is empty
P 03 00000005
P 0e ffffff05
I 080ca000 10 0000000a
I 18990000 11 fffffffe
I 2935c000 12 ffff0001
I 39b5e000 13 ffff0053
I 4a38a000 14 ffffff00
I 5ab4c000 15 00000001
I 5b3da000 16 00000000
I 6bbc1f9c 17 ffffffec
I 0c0d0000 18 00000008
I 0ce30000 19 00000010
I 1d670000 1a 00000008
N 70000000
I 6c680005 18 0000000d
I 4de32000 1b 0000001d
I 5e636000 1c 00000001
I 00736000 00 0000001e
N 70000000
I 2e81e000 1d 00000010
I 6e701fff 1c 00000000
P 00 0000001e
P 10 0000000a
P 17 ffffffec
P 18 0000000d
P 19 00000010
P 1a 00000008
P 1b 0000001d
P 1c 00000000
P 1d 00000010

//--- src.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/miniCpuTop.sv
bench/miniCpuTb.sv

//--- verilog/cpuPkg.sv
`default_nettype none

`include "miniCpu_consts.svh"

package cpuPkg;

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////

	// Operation carried in the top field of the instruction
	typedef enum logic [`OP_MSB-`OP_LSB:0]
	{
		opAdd  = 4'h0,
		opSub  = 4'h1,
		opAnd  = 4'h2,
		opOr   = 4'h3,
		opXor  = 4'h4,
		opSlt  = 4'h5,
		opAddi = 4'h6,
		opNop  = 4'h7
	} aluOp;

	////////////////////////////////////////
	// Datapath types
	////////////////////////////////////////

	typedef logic [$clog2(`REG_COUNT)-1:0] regAddr;
	typedef logic [`WORD_BITS-1:0] word;

endpackage

`default_nettype wire

//--- verilog/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "miniCpu_consts.svh"

module decodeStage
	import cpuPkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         run,
	input  wire         instrValid,
	input  wire word    instr,
	output regAddr      rsAddr,
	output regAddr      rtAddr,
	input  wire word    rsData,
	input  wire word    rtData,
	input  wire         aluValid,
	input  wire regAddr aluDest,
	input  wire word    aluResult,
	output logic        decodeValid,
	output aluOp        decodeOp,
	output regAddr      decodeDest,
	output word         operandA,
	output word         operandB
);

	aluOp                 opField;
	regAddr               rdField;
	regAddr               rsField;
	regAddr               rtField;
	logic [`IMM_BITS-1:0] immField;
	word                  immExt;
	word                  fwdA;
	word                  fwdB;

	////////////////////////////////////////
	// Field split
	////////////////////////////////////////

	assign opField  = aluOp'(instr[`OP_MSB:`OP_LSB]);
	assign rdField  = instr[`RD_MSB:`RD_LSB];
	assign rsField  = instr[`RS_MSB:`RS_LSB];
	assign rtField  = instr[`RT_MSB:`RT_LSB];
	assign immField = instr[`IMM_BITS-1:0];

	assign rsAddr = rsField;
	assign rtAddr = rtField;

	assign immExt = {{(`WORD_BITS - `IMM_BITS){immField[`IMM_BITS-1]}}, immField};

	// Previous instruction's result beats the file
	assign fwdA = (aluValid && aluDest == rsField) ? aluResult : rsData;
	assign fwdB = (aluValid && aluDest == rtField) ? aluResult : rtData;

	////////////////////////////////////////
	// Decode registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			decodeValid <= 1'b0;
		else if (run)
			decodeValid <= instrValid;
	end

	always_ff @(posedge clk)
	begin
		if (run && instrValid)
		begin
			decodeOp   <= opField;
			decodeDest <= rdField;
			operandA   <= fwdA;
			operandB   <= (opField == opAddi) ? immExt : fwdB;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		(run && instrValid) |->
		opField inside {opAdd, opSub, opAnd, opOr, opXor, opSlt, opAddi, opNop})
		else $error("decodeStage: illegal opcode %h accepted", instr[`OP_MSB:`OP_LSB]);

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage
	import cpuPkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         run,
	input  wire         decodeValid,
	input  wire aluOp   decodeOp,
	input  wire regAddr decodeDest,
	input  wire word    operandA,
	input  wire word    operandB,
	output logic        aluValid,
	output regAddr      aluDest,
	output word         aluResult,
	output logic        resultValid,
	output regAddr      resultDest,
	output word         resultData
);

	logic less;

	////////////////////////////////////////
	// ALU
	////////////////////////////////////////

	assign less = $signed(operandA) < $signed(operandB);

	always_comb
	begin
		case (decodeOp)
			// Immediate already sits in operandB
			opAdd, opAddi: aluResult = operandA + operandB;
			opSub:         aluResult = operandA - operandB;
			opAnd:         aluResult = operandA & operandB;
			opOr:          aluResult = operandA | operandB;
			opXor:         aluResult = operandA ^ operandB;
			opSlt:         aluResult = word'(less);
			default:       aluResult = '0;
		endcase
	end

	// Nop flows through without a result
	assign aluValid = decodeValid && (decodeOp != opNop);
	assign aluDest  = decodeDest;

	////////////////////////////////////////
	// Result registers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			resultValid <= 1'b0;
		else if (run)
			resultValid <= aluValid;
	end

	always_ff @(posedge clk)
	begin
		if (run && aluValid)
		begin
			resultDest <= aluDest;
			resultData <= aluResult;
		end
	end

	assert property (@(posedge clk) disable iff (reset) !$isunknown(resultValid))
		else $error("executeStage: resultValid unknown after reset");

endmodule

`default_nettype wire

//--- verilog/miniCpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module miniCpuTop
	import cpuPkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         preset,
	input  wire         run,
	input  wire         instrValid,
	input  wire word    instr,
	input  wire regAddr peekAddr,
	output logic        resultValid,
	output regAddr      resultDest,
	output word         resultData,
	output word         peekData
);

	// Operand reads
	regAddr rsAddr;
	regAddr rtAddr;
	word    rsData;
	word    rtData;

	// Forward path from execute
	logic   aluValid;
	regAddr aluDest;
	word    aluResult;

	// Decode to execute
	logic   decodeValid;
	aluOp   decodeOp;
	regAddr decodeDest;
	word    operandA;
	word    operandB;

	decodeStage decodeStage_inst (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.instrValid  (instrValid),
		.instr       (instr),
		.rsAddr      (rsAddr),
		.rtAddr      (rtAddr),
		.rsData      (rsData),
		.rtData      (rtData),
		.aluValid    (aluValid),
		.aluDest     (aluDest),
		.aluResult   (aluResult),
		.decodeValid (decodeValid),
		.decodeOp    (decodeOp),
		.decodeDest  (decodeDest),
		.operandA    (operandA),
		.operandB    (operandB)
	);

	executeStage executeStage_inst (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.decodeValid (decodeValid),
		.decodeOp    (decodeOp),
		.decodeDest  (decodeDest),
		.operandA    (operandA),
		.operandB    (operandB),
		.aluValid    (aluValid),
		.aluDest     (aluDest),
		.aluResult   (aluResult),
		.resultValid (resultValid),
		.resultDest  (resultDest),
		.resultData  (resultData)
	);

	// Result registers double as the write port
	regFile regFile_inst (
		.clk         (clk),
		.reset       (reset),
		.preset      (preset),
		.run         (run),
		.rsAddr      (rsAddr),
		.rtAddr      (rtAddr),
		.peekAddr    (peekAddr),
		.writeEnable (resultValid),
		.writeAddr   (resultDest),
		.writeData   (resultData),
		.rsData      (rsData),
		.rtData      (rtData),
		.peekData    (peekData)
	);

endmodule

`default_nettype wire

//--- verilog/miniCpu_consts.svh
`ifndef MINICPU_CONSTS_SVH
`define MINICPU_CONSTS_SVH

////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////

`define WORD_BITS 32
`define REG_COUNT 32

////////////////////////////////////////
// Instruction fields
////////////////////////////////////////

`define OP_MSB 31
`define OP_LSB 28
`define RD_MSB 27
`define RD_LSB 23
`define RS_MSB 22
`define RS_LSB 18
`define RT_MSB 17
`define RT_LSB 13
// Immediate sits in the low bits
`define IMM_BITS 13

////////////////////////////////////////
// Preset table
////////////////////////////////////////

`define PRESET_0  32'd2
`define PRESET_1  32'd2
`define PRESET_2  32'd2
`define PRESET_3  32'd5
`define PRESET_4  32'd2
`define PRESET_5  32'd5
`define PRESET_6  32'd1
`define PRESET_7  32'd2
`define PRESET_8  32'd3
`define PRESET_9  32'd0
`define PRESET_10 32'd0
`define PRESET_11 32'd0
`define PRESET_12 32'd0
`define PRESET_13 32'hFFFF0003
`define PRESET_14 32'hFFFFFF05
`define PRESET_15 32'd80
// Registers 16 to 31
`define PRESET_REST 32'd0

`endif

//--- verilog/regFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "miniCpu_consts.svh"

module regFile
	import cpuPkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         preset,
	input  wire         run,
	input  wire regAddr rsAddr,
	input  wire regAddr rtAddr,
	input  wire regAddr peekAddr,
	input  wire         writeEnable,
	input  wire regAddr writeAddr,
	input  wire word    writeData,
	output word         rsData,
	output word         rtData,
	output word         peekData
);

	localparam int PRESET_COUNT = 16;

	localparam word presetTable [PRESET_COUNT] = '{
		`PRESET_0,  `PRESET_1,  `PRESET_2,  `PRESET_3,
		`PRESET_4,  `PRESET_5,  `PRESET_6,  `PRESET_7,
		`PRESET_8,  `PRESET_9,  `PRESET_10, `PRESET_11,
		`PRESET_12, `PRESET_13, `PRESET_14, `PRESET_15
	};

	word  bank [`REG_COUNT];
	logic writeNow;

	// Preset blocks writes, a stall holds them off
	assign writeNow = writeEnable && run && !preset;

	////////////////////////////////////////
	// Bank update
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (preset)
		begin
			for (int i = 0; i < PRESET_COUNT; i++)
				bank[i] <= presetTable[i];
			for (int i = PRESET_COUNT; i < `REG_COUNT; i++)
				bank[i] <= `PRESET_REST;
		end
		else if (writeNow)
		begin
			bank[writeAddr] <= writeData;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////

	// Operand reads see the write landing this edge
	assign rsData = (writeNow && rsAddr == writeAddr) ? writeData : bank[rsAddr];
	assign rtData = (writeNow && rtAddr == writeAddr) ? writeData : bank[rtAddr];

	// Plain view of the stored contents
	assign peekData = bank[peekAddr];

	// Execute stage clears its result on reset, so no write follows a reset edge
	assert property (@(posedge clk) (reset && preset && run) |=> !writeEnable)
		else $error("regFile: write enable high right after reset under preset");

endmodule

`default_nettype wire
